/* src/mips_pkg.sv */
`default_nettype none

package mips_pkg;

        typedef logic [31:0] word_t;

        // Primary opcodes in instr[31:26].
        typedef enum logic [5:0] {
                OP_SPECIAL = 6'h00,
                OP_BEQ     = 6'h04,
                OP_BNE     = 6'h05,
                OP_BLEZ    = 6'h06,
                OP_BGTZ    = 6'h07,
                OP_ADDIU   = 6'h09,
                OP_LW      = 6'h23,
                OP_SW      = 6'h2B
        } opcode_t;

        // Function codes of SPECIAL in instr[5:0].
        typedef enum logic [5:0] {
                FN_JR   = 6'h08,
                FN_ADDU = 6'h21,
                FN_SUBU = 6'h23,
                FN_AND  = 6'h24,
                FN_OR   = 6'h25,
                FN_SLT  = 6'h2A
        } funct_t;

        typedef enum logic [2:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_SLT
        } alu_op_t;

        typedef enum logic [2:0] {
                BR_NONE,
                BR_EQ,
                BR_NE,
                BR_LEZ,
                BR_GTZ,
                BR_JR
        } branch_t;

        typedef enum logic {
                SRC_RT,
                SRC_IMM
        } alu_src_t;

        localparam logic [4:0] REG_V0 = 5'd2;

endpackage

`default_nettype wire

/* src/mips_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mips_ctrl_if;
        import mips_pkg::*;

        alu_op_t  alu_op;
        alu_src_t alu_src;
        logic     reg_write;
        // Destination is rd when set, rt otherwise.
        logic     reg_dst_rd;
        logic     mem_to_reg;
        branch_t  branch;

        modport dec (
                output alu_op, alu_src, reg_write, reg_dst_rd, mem_to_reg, branch
        );

        modport dp (
                input alu_op, alu_src, reg_write, reg_dst_rd, mem_to_reg, branch
        );

endinterface

`default_nettype wire

/* src/mips_control.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_control (
        input  mips_pkg::word_t instr,
        input  logic            active,
        output logic            data_write,
        output logic            data_read,
        mips_ctrl_if.dec        ctrl
);
        import mips_pkg::*;

        opcode_t opcode;
        funct_t  funct;
        logic    mem_wr;
        logic    mem_rd;

        assign opcode = opcode_t'(instr[31:26]);
        assign funct  = funct_t'(instr[5:0]);

        always_comb begin
                ctrl.alu_op     = ALU_ADD;
                ctrl.alu_src    = SRC_RT;
                ctrl.reg_write  = 1'b0;
                ctrl.reg_dst_rd = 1'b0;
                ctrl.mem_to_reg = 1'b0;
                ctrl.branch     = BR_NONE;
                mem_wr          = 1'b0;
                mem_rd          = 1'b0;
                case (opcode)
                        OP_SPECIAL: begin
                                ctrl.reg_dst_rd = 1'b1;
                                case (funct)
                                        FN_ADDU: begin
                                                ctrl.reg_write = 1'b1;
                                        end
                                        FN_SUBU: begin
                                                ctrl.alu_op    = ALU_SUB;
                                                ctrl.reg_write = 1'b1;
                                        end
                                        FN_AND: begin
                                                ctrl.alu_op    = ALU_AND;
                                                ctrl.reg_write = 1'b1;
                                        end
                                        FN_OR: begin
                                                ctrl.alu_op    = ALU_OR;
                                                ctrl.reg_write = 1'b1;
                                        end
                                        FN_SLT: begin
                                                ctrl.alu_op    = ALU_SLT;
                                                ctrl.reg_write = 1'b1;
                                        end
                                        FN_JR: begin
                                                ctrl.branch = BR_JR;
                                        end
                                        default: begin
                                                // Unknown function code runs as a no-op.
                                                ctrl.reg_dst_rd = 1'b0;
                                        end
                                endcase
                        end
                        OP_ADDIU: begin
                                ctrl.alu_src   = SRC_IMM;
                                ctrl.reg_write = 1'b1;
                        end
                        OP_LW: begin
                                ctrl.alu_src    = SRC_IMM;
                                ctrl.reg_write  = 1'b1;
                                ctrl.mem_to_reg = 1'b1;
                                mem_rd          = 1'b1;
                        end
                        OP_SW: begin
                                ctrl.alu_src = SRC_IMM;
                                mem_wr       = 1'b1;
                        end
                        OP_BEQ:  ctrl.branch = BR_EQ;
                        OP_BNE:  ctrl.branch = BR_NE;
                        OP_BLEZ: ctrl.branch = BR_LEZ;
                        OP_BGTZ: ctrl.branch = BR_GTZ;
                        default: begin
                                ctrl.branch = BR_NONE;
                        end
                endcase
        end

        // Memory strobes only while the core runs.
        assign data_write = mem_wr & active;
        assign data_read  = mem_rd & active;

endmodule

`default_nettype wire

/* src/mips_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
        input  logic            clk,
        input  logic            arst_n,
        input  logic            clk_enable,
        input  logic            write_en,
        input  logic [4:0]      rs_addr,
        input  logic [4:0]      rt_addr,
        input  logic [4:0]      rd_addr,
        input  mips_pkg::word_t rd_data,
        output mips_pkg::word_t rs_data,
        output mips_pkg::word_t rt_data,
        output mips_pkg::word_t v0
);
        import mips_pkg::*;

        word_t regs [32];

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (clk_enable && write_en && rd_addr != 5'd0) begin
                        regs[rd_addr] <= rd_data;
                end
        end

        // $0 never gets written, so it reads as zero.
        assign rs_data = regs[rs_addr];
        assign rt_data = regs[rt_addr];
        assign v0      = regs[REG_V0];

endmodule

`default_nettype wire

/* src/mips_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
        input  mips_pkg::word_t a,
        input  mips_pkg::word_t b,
        output mips_pkg::word_t result,
        output logic            branch_taken,
        mips_ctrl_if.dp         ctrl
);
        import mips_pkg::*;

        always_comb begin
                case (ctrl.alu_op)
                        ALU_ADD: result = a + b;
                        ALU_SUB: result = a - b;
                        ALU_AND: result = a & b;
                        ALU_OR:  result = a | b;
                        ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
                        default: result = a + b;
                endcase
        end

        // Branch condition on rs and rt; BLEZ and BGTZ look at rs only.
        always_comb begin
                case (ctrl.branch)
                        BR_EQ:   branch_taken = (a == b);
                        BR_NE:   branch_taken = (a != b);
                        BR_LEZ:  branch_taken = ($signed(a) <= 32'sd0);
                        BR_GTZ:  branch_taken = ($signed(a) > 32'sd0);
                        BR_JR:   branch_taken = 1'b1;
                        default: branch_taken = 1'b0;
                endcase
        end

endmodule

`default_nettype wire

/* src/mips_pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_pc_unit #(
        parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC0_0000
) (
        input  logic            clk,
        input  logic            arst_n,
        input  logic            clk_enable,
        input  logic            branch_taken,
        input  mips_pkg::word_t imm,
        input  mips_pkg::word_t jr_target,
        output mips_pkg::word_t pc,
        output logic            active,
        mips_ctrl_if.dp         ctrl
);
        import mips_pkg::*;

        word_t pc_plus4;
        word_t target;
        word_t next_pc;
        word_t pending_target;
        logic  pending;

        assign pc_plus4 = pc + 32'd4;

        // Branch offset counts from the delay slot address.
        assign target = (ctrl.branch == BR_JR) ? jr_target
                                               : pc_plus4 + {imm[29:0], 2'b00};

        assign next_pc = pending ? pending_target : pc_plus4;

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        pc      <= RESET_VECTOR;
                        pending <= 1'b0;
                        active  <= 1'b1;
                end else if (clk_enable && active) begin
                        pc      <= next_pc;
                        pending <= branch_taken;
                        if (next_pc == '0) begin
                                active <= 1'b0;
                        end
                end
        end

        // Target waits here while the delay slot runs.
        always_ff @(posedge clk) begin
                if (clk_enable && active && branch_taken) begin
                        pending_target <= target;
                end
        end

endmodule

`default_nettype wire

/* src/mips_cpu_harvard.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_harvard #(
        parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC0_0000
) (
        input  logic            clk,
        input  logic            arst_n,
        output logic            active,
        output mips_pkg::word_t register_v0,
        input  logic            clk_enable,

        output mips_pkg::word_t instr_address,
        input  mips_pkg::word_t instr_readdata,

        output mips_pkg::word_t data_address,
        output logic            data_write,
        output logic            data_read,
        output mips_pkg::word_t data_writedata,
        input  mips_pkg::word_t data_readdata
);
        import mips_pkg::*;

        mips_ctrl_if ctrl_bus ();

        word_t      pc;
        word_t      rs_data;
        word_t      rt_data;
        word_t      imm_ext;
        word_t      alu_b;
        word_t      alu_result;
        word_t      wb_data;
        logic [4:0] dest_reg;
        logic       dec_write;
        logic       reg_we;
        logic       branch_taken;

        assign instr_address = pc;

        assign imm_ext = {{16{instr_readdata[15]}}, instr_readdata[15:0]};
        assign alu_b   = (ctrl_bus.alu_src == SRC_IMM) ? imm_ext : rt_data;

        assign dest_reg = ctrl_bus.reg_dst_rd ? instr_readdata[15:11] : instr_readdata[20:16];
        assign wb_data  = ctrl_bus.mem_to_reg ? data_readdata : alu_result;
        assign reg_we   = ctrl_bus.reg_write & active;

        assign data_address   = alu_result;
        assign data_writedata = rt_data;
        // A stalled cycle must leave memory untouched.
        assign data_write     = dec_write & clk_enable;

        mips_control u_control (
                .instr      (instr_readdata),
                .active     (active),
                .data_write (dec_write),
                .data_read  (data_read),
                .ctrl       (ctrl_bus)
        );

        mips_regfile u_regfile (
                .clk        (clk),
                .arst_n     (arst_n),
                .clk_enable (clk_enable),
                .write_en   (reg_we),
                .rs_addr    (instr_readdata[25:21]),
                .rt_addr    (instr_readdata[20:16]),
                .rd_addr    (dest_reg),
                .rd_data    (wb_data),
                .rs_data    (rs_data),
                .rt_data    (rt_data),
                .v0         (register_v0)
        );

        mips_alu u_alu (
                .a            (rs_data),
                .b            (alu_b),
                .result       (alu_result),
                .branch_taken (branch_taken),
                .ctrl         (ctrl_bus)
        );

        mips_pc_unit #(
                .RESET_VECTOR (RESET_VECTOR)
        ) u_pc_unit (
                .clk          (clk),
                .arst_n       (arst_n),
                .clk_enable   (clk_enable),
                .branch_taken (branch_taken),
                .imm          (imm_ext),
                .jr_target    (rs_data),
                .pc           (pc),
                .active       (active),
                .ctrl         (ctrl_bus)
        );

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
        parameter int PERIOD_NS    = 8,
        parameter int RESET_CYCLES = 5
) (
        input  logic restart,
        output logic clk,
        output logic arst_n
);
        int count = 0;

        initial begin
                clk = 1'b0;
        end

        always #(PERIOD_NS / 2) clk = ~clk;

        // Reset stays low until enough edges have passed since the last restart.
        always @(posedge clk) begin
                if (restart) begin
                        count <= 0;
                end else if (count < RESET_CYCLES) begin
                        count <= count + 1;
                end
        end

        assign arst_n = (count >= RESET_CYCLES);

endmodule

`default_nettype wire

/* bench/tb_data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_data_memory (
        input  logic        clk,
        input  logic        clear,
        input  logic [31:0] address,
        input  logic        write,
        input  logic        read,
        input  logic [31:0] writedata,
        output logic [31:0] readdata
);
        // The test programs fit in 64 words.
        logic [31:0] mem [64];

        always @(posedge clk) begin
                if (clear) begin
                        for (int i = 0; i < 64; i++) begin
                                mem[i] <= '0;
                        end
                end else if (write) begin
                        mem[address[7:2]] <= writedata;
                end
        end

        assign readdata = read ? mem[address[7:2]] : '0;

endmodule

`default_nettype wire

/* bench/tb_mips_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_cpu;

        localparam logic [31:0] RESET_VECTOR = 32'hBFC0_0000;

        logic        clk;
        logic        arst_n;
        logic        restart    = 1'b0;
        logic        clk_enable = 1'b0;
        logic        active;
        logic [31:0] register_v0;
        logic [31:0] instr_address;
        logic [31:0] instr_readdata;
        logic [31:0] data_address;
        logic        data_write;
        logic        data_read;
        logic [31:0] data_writedata;
        logic [31:0] data_readdata;

        logic [31:0] testdata [256];
        logic [31:0] prog [64];
        logic [31:0] fetch_offset;
        logic [31:0] expected_v0;
        logic [31:0] lfsr = 32'd78317;
        logic        stall_mode;
        int          prog_len = 0;
        int          pass_count = 0;
        int          fail_count = 0;
        int          timed_out = 0;

        tb_clock u_clock (
                .restart (restart),
                .clk     (clk),
                .arst_n  (arst_n)
        );

        tb_data_memory u_dmem (
                .clk       (clk),
                .clear     (restart),
                .address   (data_address),
                .write     (data_write),
                .read      (data_read),
                .writedata (data_writedata),
                .readdata  (data_readdata)
        );

        mips_cpu_harvard #(
                .RESET_VECTOR (RESET_VECTOR)
        ) dut (
                .clk            (clk),
                .arst_n         (arst_n),
                .active         (active),
                .register_v0    (register_v0),
                .clk_enable     (clk_enable),
                .instr_address  (instr_address),
                .instr_readdata (instr_readdata),
                .data_address   (data_address),
                .data_write     (data_write),
                .data_read      (data_read),
                .data_writedata (data_writedata),
                .data_readdata  (data_readdata)
        );

        // Outside the program the fetch returns a no-op.
        always_comb begin
                fetch_offset = instr_address - RESET_VECTOR;
                if (fetch_offset < 32'(prog_len * 4)) begin
                        instr_readdata = prog[fetch_offset[7:2]];
                end else begin
                        instr_readdata = '0;
                end
        end

        function automatic logic [31:0] lfsr_step(input logic [31:0] state);
                if (state[0]) begin
                        return (state >> 1) ^ 32'hB4BC_D35C;
                end
                return state >> 1;
        endfunction

        task automatic take_bit(output logic b);
                b    = lfsr[0];
                lfsr = lfsr_step(lfsr);
        endtask

        // A stalled program loses about one cycle in four.
        task automatic pick_enable(output logic en);
                logic b0;
                logic b1;
                en = 1'b1;
                if (stall_mode) begin
                        take_bit(b0);
                        take_bit(b1);
                        en = !(b0 && b1);
                end
        endtask

        task automatic load_program(inout int ptr);
                prog_len = testdata[8'(ptr)];
                for (int i = 0; i < 64; i++) begin
                        prog[6'(i)] = '0;
                end
                for (int i = 0; i < prog_len; i++) begin
                        prog[6'(i)] = testdata[8'(ptr + 1 + i)];
                end
                expected_v0 = testdata[8'(ptr + 1 + prog_len)];
                stall_mode  = testdata[8'(ptr + 2 + prog_len)][0];
                ptr         = ptr + 3 + prog_len;
        endtask

        task automatic apply_reset;
                @(posedge clk);
                restart    <= 1'b1;
                clk_enable <= 1'b0;
                @(posedge clk);
                restart    <= 1'b0;
                @(negedge clk);
                while (!arst_n) begin
                        @(negedge clk);
                end
        endtask

        task automatic run_program(input int num);
                int   cycles;
                int   limit;
                logic en;
                logic ok;
                cycles = 0;
                limit  = 8 * prog_len + 100;
                ok     = 1'b1;
                while (active && cycles < limit) begin
                        @(posedge clk);
                        pick_enable(en);
                        clk_enable <= en;
                        @(negedge clk);
                        cycles++;
                end
                if (active) begin
                        $display("program %0d: the core never halted within %0d cycles",
                                 num, limit);
                        fail_count++;
                        timed_out = 1;
                end else begin
                        assert (register_v0 == expected_v0) else begin
                                $display("ERROR time=%0t register_v0 got=%h expected=%h",
                                         $time, register_v0, expected_v0);
                                ok = 1'b0;
                        end
                        @(posedge clk);
                        clk_enable <= 1'b1;
                        repeat (10) begin
                                @(negedge clk);
                                assert (!active && !data_write) else begin
                                        $display("program %0d: the core left the halted state",
                                                 num);
                                        ok = 1'b0;
                                end
                        end
                        if (ok) begin
                                pass_count++;
                        end else begin
                                fail_count++;
                        end
                        $display("program %0d: %s after %0d cycles", num,
                                 ok ? "PASS" : "FAIL", cycles);
                end
        endtask

        initial begin
                int num_programs;
                int ptr;
                $readmemh("bench/testdata_programs.hex", testdata);
                num_programs = testdata[0];
                ptr          = 1;
                for (int p = 0; p < num_programs && timed_out == 0; p++) begin
                        load_program(ptr);
                        apply_reset();
                        run_program(p + 1);
                end
                $display("Programs passed: %0d, failed: %0d", pass_count, fail_count);
                if (num_programs > 0 && fail_count == 0 && pass_count == num_programs) begin
                        $display("Test completed successfully");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* bench/testdata_programs.hex */
// Program count, then per program: length, instruction words from BFC00000,
// expected register_v0 and stall flag.
6
// ALU chain with a write to $0.
10
24080064 24090025 01095021 01495823
01496024 016C6825 0128702A 240FFFFB
01EEC02A 25000037 01AE1021 00581021
00401021 004F1021 00000008 00000000
00000062 0
// BLEZ taken and not taken.
09
24020001 18000002 2442003F 244203E8
00421021 18400002 24030005 00000008
00000000
00000080 0
// BGTZ taken and not taken, BLEZ on a negative value.
0A
2404FFFD 1C800003 2402000A 1C400002
24420005 24420064 18800001 00421021
00000008 24420002
00000020 0
// BNE loop, BEQ taken and not taken.
0D
24050004 24020000 00451021 24A5FFFF
14A0FFFD 2442000A 10A00002 24420001
244201F4 10400002 24420002 00000008
00000000
00000035 0
// SW then LW.
0A
24060040 24071234 00073823 ACC70004
ACC60008 8CC20004 8CC30008 00431021
00000008 00000000
FFFFEE0C 0
// BNE loop again with stalls.
0D
24050004 24020000 00451021 24A5FFFF
14A0FFFD 2442000A 10A00002 24420001
244201F4 10400002 24420002 00000008
00000000
00000035 1

/* sim.f */
src/mips_pkg.sv
src/mips_ctrl_if.sv
src/mips_control.sv
src/mips_regfile.sv
src/mips_alu.sv
src/mips_pc_unit.sv
src/mips_cpu_harvard.sv
bench/tb_clock.sv
bench/tb_data_memory.sv
bench/tb_mips_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mips_cpu
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
